// File: mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Number of fully associative data TLB entries
`define TLB_ENTRIES 4

// Slots in the TLB miss queue
`define MQ_SIZE 4

// Store-queue sequence number width, compared with wrap-around
`define SQN_W 7

`endif

// File: mmuPkg.sv
`include "mmu_defs.svh"

package mmuPkg;

    typedef enum logic [1:0] {
        OpLoad,
        OpStore
    } MemOp;

    typedef enum logic [2:0] {
        WalkIdle,
        WalkL1Req,
        WalkL1Resp,
        WalkL0Req,
        WalkL0Resp,
        WalkFill
    } WalkState;

    // True when sqN is younger than refSqN
    function automatic logic isYounger(input logic [`SQN_W-1:0] sqN,
                                       input logic [`SQN_W-1:0] refSqN);
        logic signed [`SQN_W-1:0] diff;
        diff = sqN - refSqN;
        return diff > 0;
    endfunction

    // Superpages only compare the level-1 index
    function automatic logic vpnMatch(input logic [19:0] vpnA,
                                      input logic [19:0] vpnB,
                                      input logic isSuper);
        return isSuper ? (vpnA[19:10] == vpnB[19:10]) : (vpnA == vpnB);
    endfunction

endpackage

// File: dataTlb.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module dataTlb (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vmemEn,
    input  logic                 aguValid,
    input  logic [31:0]          aguAddr,
    input  logic [`SQN_W-1:0]    aguSqN,
    input  mmuPkg::MemOp         aguOp,
    output logic                 aguStall,
    input  logic                 replayValid,
    input  logic [31:0]          replayAddr,
    input  logic [`SQN_W-1:0]    replaySqN,
    input  mmuPkg::MemOp         replayOp,
    output logic                 replayTake,
    input  logic                 mqStall,
    input  logic                 branchTaken,
    input  logic [`SQN_W-1:0]    branchSqN,
    input  logic                 fillValid,
    input  logic [19:0]          fillVpn,
    input  logic [19:0]          fillPpn,
    input  logic                 fillSuper,
    input  logic                 walkBusy,
    output logic                 missValid,
    output logic [31:0]          missAddr,
    output logic [`SQN_W-1:0]    missSqN,
    output mmuPkg::MemOp         missOp,
    output logic                 walkReq,
    output logic [19:0]          walkVpn,
    output logic                 outValid,
    output logic [31:0]          outPaddr,
    output logic [`SQN_W-1:0]    outSqN,
    output mmuPkg::MemOp         outOp
);
    localparam int idxW = $clog2(`TLB_ENTRIES);

    logic [`TLB_ENTRIES-1:0] entValid;
    logic [`TLB_ENTRIES-1:0] entSuper;
    logic [19:0]             entVpn [`TLB_ENTRIES];
    logic [19:0]             entPpn [`TLB_ENTRIES];
    logic [idxW-1:0]         fillPtr;

    logic                    candValid;
    logic [31:0]             candAddr;
    logic [`SQN_W-1:0]       candSqN;
    mmuPkg::MemOp            candOp;
    logic                    candLive;
    logic                    hit;
    logic [31:0]             hitPaddr;

    // A pending replay always wins the lookup slot
    assign aguStall = replayValid || mqStall;
    assign replayTake = replayValid;

    always_comb begin
        if (replayValid) begin
            candValid = 1'b1;
            candAddr = replayAddr;
            candSqN = replaySqN;
            candOp = replayOp;
        end else begin
            candValid = aguValid && !mqStall;
            candAddr = aguAddr;
            candSqN = aguSqN;
            candOp = aguOp;
        end
    end

    assign candLive = candValid && !(branchTaken && mmuPkg::isYounger(candSqN, branchSqN));

    always_comb begin
        hit = !vmemEn;
        hitPaddr = candAddr;
        if (vmemEn) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (entValid[i] && mmuPkg::vpnMatch(entVpn[i], candAddr[31:12], entSuper[i])) begin
                    hit = 1'b1;
                    hitPaddr = entSuper[i] ? {entPpn[i][19:10], candAddr[21:0]}
                                           : {entPpn[i], candAddr[11:0]};
                end
            end
            // Forward a fill landing in this cycle
            if (fillValid && mmuPkg::vpnMatch(fillVpn, candAddr[31:12], fillSuper)) begin
                hit = 1'b1;
                hitPaddr = fillSuper ? {fillPpn[19:10], candAddr[21:0]}
                                     : {fillPpn, candAddr[11:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            missValid <= 1'b0;
            walkReq <= 1'b0;
            entValid <= '0;
            fillPtr <= '0;
        end else begin
            outValid <= candLive && hit;
            missValid <= candLive && !hit;
            walkReq <= candLive && !hit && !walkBusy;
            if (fillValid) begin
                entValid[fillPtr] <= 1'b1;
                fillPtr <= fillPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        outPaddr <= hitPaddr;
        outSqN <= candSqN;
        outOp <= candOp;
        missAddr <= candAddr;
        missSqN <= candSqN;
        missOp <= candOp;
        walkVpn <= candAddr[31:12];
        if (fillValid) begin
            entVpn[fillPtr] <= fillVpn;
            entPpn[fillPtr] <= fillPpn;
            entSuper[fillPtr] <= fillSuper;
        end
    end

endmodule

// File: tlbMissQueue.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module tlbMissQueue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vmemEn,
    input  logic                 branchTaken,
    input  logic [`SQN_W-1:0]    branchSqN,
    input  logic                 fillValid,
    input  logic [19:0]          fillVpn,
    input  logic                 fillSuper,
    input  logic                 walkBusy,
    input  logic                 missValid,
    input  logic [31:0]          missAddr,
    input  logic [`SQN_W-1:0]    missSqN,
    input  mmuPkg::MemOp         missOp,
    output logic                 mqStall,
    input  logic                 replayTake,
    output logic                 replayValid,
    output logic [31:0]          replayAddr,
    output logic [`SQN_W-1:0]    replaySqN,
    output mmuPkg::MemOp         replayOp
);
    localparam int idxW = $clog2(`MQ_SIZE);

    logic [`MQ_SIZE-1:0] qValid;
    logic [`MQ_SIZE-1:0] qReady;
    logic [31:0]         qAddr [`MQ_SIZE];
    logic [`SQN_W-1:0]   qSqN [`MQ_SIZE];
    mmuPkg::MemOp        qOp [`MQ_SIZE];

    logic [idxW-1:0]     idxIn;
    logic [idxW-1:0]     idxOut;
    logic                idxOutValid;
    logic                missLive;

    // Free slot scan, stall unless two are free
    always_comb begin
        logic oneFree;
        oneFree = 1'b0;
        idxIn = '0;
        mqStall = 1'b1;
        for (int i = 0; i < `MQ_SIZE; i++) begin
            if (!qValid[i]) begin
                idxIn = idxW'(i);
                if (oneFree) begin
                    mqStall = 1'b0;
                end
                oneFree = 1'b1;
            end
        end
    end

    // Idle walker lets unready entries go out to start their own walk
    always_comb begin
        idxOut = '0;
        idxOutValid = 1'b0;
        for (int i = 0; i < `MQ_SIZE; i++) begin
            if (qValid[i] && (qReady[i] || !walkBusy)) begin
                idxOut = idxW'(i);
                idxOutValid = 1'b1;
            end
        end
    end

    assign missLive = missValid && !(branchTaken && mmuPkg::isYounger(missSqN, branchSqN));

    always_ff @(posedge clk) begin
        if (rst) begin
            qValid <= '0;
            replayValid <= 1'b0;
        end else begin
            for (int i = 0; i < `MQ_SIZE; i++) begin
                if (fillValid && qValid[i] &&
                    mmuPkg::vpnMatch(fillVpn, qAddr[i][31:12], fillSuper)) begin
                    qReady[i] <= 1'b1;
                end
                if (branchTaken && qValid[i] && mmuPkg::isYounger(qSqN[i], branchSqN)) begin
                    qValid[i] <= 1'b0;
                end
            end

            if (missLive) begin
                qValid[idxIn] <= 1'b1;
                qReady[idxIn] <= !vmemEn ||
                    (fillValid && mmuPkg::vpnMatch(fillVpn, missAddr[31:12], fillSuper));
                qAddr[idxIn] <= missAddr;
                qSqN[idxIn] <= missSqN;
                qOp[idxIn] <= missOp;
            end

            if (replayTake || (branchTaken && mmuPkg::isYounger(replaySqN, branchSqN))) begin
                replayValid <= 1'b0;
            end
            if ((!replayValid || replayTake) && idxOutValid &&
                !(branchTaken && mmuPkg::isYounger(qSqN[idxOut], branchSqN))) begin
                replayValid <= 1'b1;
                replayAddr <= qAddr[idxOut];
                replaySqN <= qSqN[idxOut];
                replayOp <= qOp[idxOut];
                qValid[idxOut] <= 1'b0;
            end
        end
    end

endmodule

// File: pageWalker.sv
`timescale 1ns/100ps

module pageWalker (
    input  logic        clk,
    input  logic        rst,
    input  logic [19:0] satpPpn,
    input  logic        walkReq,
    input  logic [19:0] walkVpn,
    output logic        walkBusy,
    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    output logic        fillValid,
    output logic [19:0] fillVpn,
    output logic [19:0] fillPpn,
    output logic        fillSuper
);
    mmuPkg::WalkState state;

    logic [19:0] vpn;
    logic [19:0] ppn;
    logic        isSuper;

    // A request not yet latched already counts as busy
    assign walkBusy = (state != mmuPkg::WalkIdle) || walkReq;

    assign arvalid = (state == mmuPkg::WalkL1Req) || (state == mmuPkg::WalkL0Req);
    assign rready = (state == mmuPkg::WalkL1Resp) || (state == mmuPkg::WalkL0Resp);
    assign araddr = (state == mmuPkg::WalkL0Req) ? ({ppn, 12'b0} + {20'b0, vpn[9:0], 2'b0})
                                                 : ({satpPpn, 12'b0} + {20'b0, vpn[19:10], 2'b0});

    assign fillValid = (state == mmuPkg::WalkFill);
    assign fillVpn = vpn;
    assign fillPpn = ppn;
    assign fillSuper = isSuper;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mmuPkg::WalkIdle;
        end else begin
            case (state)
                mmuPkg::WalkIdle: begin
                    if (walkReq) begin
                        vpn <= walkVpn;
                        state <= mmuPkg::WalkL1Req;
                    end
                end
                mmuPkg::WalkL1Req: begin
                    if (arready) state <= mmuPkg::WalkL1Resp;
                end
                mmuPkg::WalkL1Resp: begin
                    if (rvalid) begin
                        ppn <= rdata[29:10];
                        // Error response drops the walk, the queue reissues
                        if (rresp != 2'b00) begin
                            state <= mmuPkg::WalkIdle;
                        end else if (rdata[1] || rdata[3]) begin
                            isSuper <= 1'b1;
                            state <= mmuPkg::WalkFill;
                        end else begin
                            state <= mmuPkg::WalkL0Req;
                        end
                    end
                end
                mmuPkg::WalkL0Req: begin
                    if (arready) state <= mmuPkg::WalkL0Resp;
                end
                mmuPkg::WalkL0Resp: begin
                    if (rvalid) begin
                        ppn <= rdata[29:10];
                        isSuper <= 1'b0;
                        state <= (rresp != 2'b00) ? mmuPkg::WalkIdle : mmuPkg::WalkFill;
                    end
                end
                default: begin
                    state <= mmuPkg::WalkIdle;
                end
            endcase
        end
    end

endmodule

// File: dataTranslate.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module dataTranslate (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vmemEn,
    input  logic [19:0]          satpPpn,
    input  logic                 aguValid,
    input  logic [31:0]          aguAddr,
    input  logic [`SQN_W-1:0]    aguSqN,
    input  mmuPkg::MemOp         aguOp,
    output logic                 aguStall,
    input  logic                 branchTaken,
    input  logic [`SQN_W-1:0]    branchSqN,
    output logic                 arvalid,
    input  logic                 arready,
    output logic [31:0]          araddr,
    input  logic                 rvalid,
    output logic                 rready,
    input  logic [31:0]          rdata,
    input  logic [1:0]           rresp,
    output logic                 outValid,
    output logic [31:0]          outPaddr,
    output logic [`SQN_W-1:0]    outSqN,
    output mmuPkg::MemOp         outOp
);
    logic               replayValid;
    logic [31:0]        replayAddr;
    logic [`SQN_W-1:0]  replaySqN;
    mmuPkg::MemOp       replayOp;
    logic               replayTake;
    logic               mqStall;

    logic               missValid;
    logic [31:0]        missAddr;
    logic [`SQN_W-1:0]  missSqN;
    mmuPkg::MemOp       missOp;

    logic               walkReq;
    logic [19:0]        walkVpn;
    logic               walkBusy;
    logic               fillValid;
    logic [19:0]        fillVpn;
    logic [19:0]        fillPpn;
    logic               fillSuper;

    dataTlb tlb (
        .clk(clk), .rst(rst), .vmemEn(vmemEn),
        .aguValid(aguValid), .aguAddr(aguAddr), .aguSqN(aguSqN), .aguOp(aguOp),
        .aguStall(aguStall),
        .replayValid(replayValid), .replayAddr(replayAddr), .replaySqN(replaySqN),
        .replayOp(replayOp), .replayTake(replayTake), .mqStall(mqStall),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .fillValid(fillValid), .fillVpn(fillVpn), .fillPpn(fillPpn), .fillSuper(fillSuper),
        .walkBusy(walkBusy),
        .missValid(missValid), .missAddr(missAddr), .missSqN(missSqN), .missOp(missOp),
        .walkReq(walkReq), .walkVpn(walkVpn),
        .outValid(outValid), .outPaddr(outPaddr), .outSqN(outSqN), .outOp(outOp)
    );

    tlbMissQueue missQueue (
        .clk(clk), .rst(rst), .vmemEn(vmemEn),
        .branchTaken(branchTaken), .branchSqN(branchSqN),
        .fillValid(fillValid), .fillVpn(fillVpn), .fillSuper(fillSuper),
        .walkBusy(walkBusy),
        .missValid(missValid), .missAddr(missAddr), .missSqN(missSqN), .missOp(missOp),
        .mqStall(mqStall), .replayTake(replayTake),
        .replayValid(replayValid), .replayAddr(replayAddr), .replaySqN(replaySqN),
        .replayOp(replayOp)
    );

    pageWalker walker (
        .clk(clk), .rst(rst), .satpPpn(satpPpn),
        .walkReq(walkReq), .walkVpn(walkVpn), .walkBusy(walkBusy),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .fillValid(fillValid), .fillVpn(fillVpn), .fillPpn(fillPpn), .fillSuper(fillSuper)
    );

endmodule

// File: tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: dataTranslate_assert.sv
`timescale 1ns/100ps

module dataTranslateAssert (
    input logic        clk,
    input logic        rst,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        outValid,
    input logic        fillValid
);
    arAddrStable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> $stable(araddr))
        else $error("araddr changed while the read request was waiting");

    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !outValid && !arvalid && !fillValid)
        else $error("outputs active in the first cycle after reset");

    singleFill: assert property (@(posedge clk) disable iff (rst)
        fillValid |=> !fillValid)
        else $error("fill pulse lasted more than one cycle");

endmodule

bind dataTranslate dataTranslateAssert assertInst (
    .clk(clk),
    .rst(rst),
    .arvalid(arvalid),
    .arready(arready),
    .araddr(araddr),
    .outValid(outValid),
    .fillValid(fillValid)
);

// File: tbDataTranslate.sv
`timescale 1ns/100ps
`include "mmu_defs.svh"

module tbDataTranslate;
    localparam int numOps = 400;
    localparam int timeoutCycles = numOps * 60;
    localparam int sqnSpan = 1 << `SQN_W;
    localparam logic [19:0] rootPpn = 20'h00100;

    logic               clk;
    logic               rst;
    logic               vmemEn;
    logic               aguValid;
    logic [31:0]        aguAddr;
    logic [`SQN_W-1:0]  aguSqN;
    mmuPkg::MemOp       aguOp;
    logic               aguStall;
    logic               branchTaken;
    logic [`SQN_W-1:0]  branchSqN;
    logic               arvalid;
    logic               arready;
    logic [31:0]        araddr;
    logic               rvalid;
    logic               rready;
    logic [31:0]        rdata;
    logic [1:0]         rresp;
    logic               outValid;
    logic [31:0]        outPaddr;
    logic [`SQN_W-1:0]  outSqN;
    mmuPkg::MemOp       outOp;

    // Page table model with eight distinct level-1 indices
    logic [19:0]        pgVpn [8];
    logic [19:0]        pgPpn [8];
    logic [19:0]        pgTbl [8];
    logic               pgSuper [8];
    logic               pageSeen [8];
    logic [31:0]        ptMem [logic [31:0]];

    // Scoreboard keyed by sequence number
    logic               sbValid [sqnSpan];
    logic [31:0]        sbPaddr [sqnSpan];
    mmuPkg::MemOp       sbOp [sqnSpan];
    int                 sbCycle [sqnSpan];
    logic               sbVmem [sqnSpan];

    logic [31:0]        stimRng;
    logic [31:0]        memRng;
    logic [1:0]         memDelay;
    logic               rPending;
    logic [31:0]        rAddr;
    int                 pending;
    int                 cycle;
    logic               failed;

    tbClock clockGen (.clk(clk), .rst(rst));

    dataTranslate UUT (
        .clk(clk), .rst(rst), .vmemEn(vmemEn), .satpPpn(rootPpn),
        .aguValid(aguValid), .aguAddr(aguAddr), .aguSqN(aguSqN), .aguOp(aguOp),
        .aguStall(aguStall), .branchTaken(branchTaken), .branchSqN(branchSqN),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .outValid(outValid), .outPaddr(outPaddr), .outSqN(outSqN), .outOp(outOp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Younger when ahead by less than half the sequence space
    function automatic logic sqnAfter(input logic [`SQN_W-1:0] a, input logic [`SQN_W-1:0] b);
        int d;
        d = (int'(a) - int'(b) + sqnSpan) % sqnSpan;
        return d != 0 && d < sqnSpan / 2;
    endfunction

    function automatic int findPage(input logic [31:0] addr);
        int idx;
        idx = 0;
        for (int i = 0; i < 8; i++) begin
            if (pgVpn[i][19:10] == addr[31:22]) idx = i;
        end
        return idx;
    endfunction

    function automatic logic [31:0] translate(input logic [31:0] addr);
        int i;
        i = findPage(addr);
        if (pgSuper[i]) return {pgPpn[i][19:10], addr[21:0]};
        return {pgPpn[i], addr[11:0]};
    endfunction

    function automatic logic legalWalkAddr(input logic [31:0] a);
        logic ok;
        logic [31:0] l1;
        logic [31:0] l0;
        ok = 1'b0;
        for (int i = 0; i < 8; i++) begin
            l1 = {rootPpn, 12'h000} + {20'h0, pgVpn[i][19:10], 2'b00};
            l0 = {pgTbl[i], 12'h000} + {20'h0, pgVpn[i][9:0], 2'b00};
            if (pageSeen[i] && (a == l1 || (!pgSuper[i] && a == l0))) ok = 1'b1;
        end
        return ok;
    endfunction

    task automatic abortRun();
        failed = 1'b1;
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    // AXI4-Lite read slave with random delays
    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rPending <= 1'b0;
            memDelay <= 2'd0;
        end else if (arready) begin
            assert (legalWalkAddr(araddr)) else begin
                $display("Error: araddr = %h matches no waiting page walk", araddr);
                abortRun();
            end
            arready <= 1'b0;
            rPending <= 1'b1;
            rAddr <= araddr;
            memRng = xorshift(memRng);
            memDelay <= memRng[1:0];
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
                memRng = xorshift(memRng);
                memDelay <= memRng[1:0];
            end
        end else if (rPending) begin
            if (memDelay == 2'd0) begin
                rvalid <= 1'b1;
                rdata <= ptMem.exists(rAddr) ? ptMem[rAddr] : 32'h0;
                rPending <= 1'b0;
            end else begin
                memDelay <= memDelay - 2'd1;
            end
        end else if (arvalid) begin
            if (memDelay == 2'd0) arready <= 1'b1;
            else memDelay <= memDelay - 2'd1;
        end
    end

    // Output checks, acceptance tracking and flush
    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            assert (cycle < timeoutCycles) else begin
                $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
                abortRun();
            end
            // Read data is accepted only while a response is owed
            assert (rready == (rPending || rvalid)) else begin
                $display("Error: rready = %h, expected %h", rready, rPending || rvalid);
                abortRun();
            end
            if (outValid) begin
                assert (sbValid[outSqN]) else begin
                    $display("Error: outSqN = %h was never accepted or was output before",
                             outSqN);
                    abortRun();
                end
                assert (outPaddr == sbPaddr[outSqN]) else begin
                    $display("Error: outPaddr = %h, expected %h", outPaddr, sbPaddr[outSqN]);
                    abortRun();
                end
                assert (outOp == sbOp[outSqN]) else begin
                    $display("Error: outOp = %h, expected %h", outOp, sbOp[outSqN]);
                    abortRun();
                end
                assert (sbVmem[outSqN] || cycle - sbCycle[outSqN] == 1) else begin
                    $display("Error: outSqN = %h came %h cycles after acceptance",
                             outSqN, cycle - sbCycle[outSqN]);
                    abortRun();
                end
                sbValid[outSqN] = 1'b0;
                pending--;
            end
            if (aguValid && !aguStall) begin
                assert (!sbValid[aguSqN]) else begin
                    $display("Error: aguSqN = %h reused while still in flight", aguSqN);
                    abortRun();
                end
                sbValid[aguSqN] = 1'b1;
                sbPaddr[aguSqN] = vmemEn ? translate(aguAddr) : aguAddr;
                sbOp[aguSqN] = aguOp;
                sbCycle[aguSqN] = cycle;
                sbVmem[aguSqN] = vmemEn;
                if (vmemEn) pageSeen[findPage(aguAddr)] = 1'b1;
                pending++;
            end
            if (branchTaken) begin
                for (int k = 0; k < sqnSpan; k++) begin
                    if (sbValid[k] && sqnAfter(k[`SQN_W-1:0], branchSqN)) begin
                        sbValid[k] = 1'b0;
                        pending--;
                    end
                end
            end
        end
    end

    initial begin
        int issued;
        int pg;
        logic [`SQN_W-1:0] nextSqN;
        vmemEn = 1'b0;
        aguValid = 1'b0;
        aguAddr = 32'h0;
        aguSqN = '0;
        aguOp = mmuPkg::OpLoad;
        branchTaken = 1'b0;
        branchSqN = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rresp = 2'b00;
        rdata = 32'h0;
        failed = 1'b0;
        pending = 0;
        cycle = 0;
        issued = 0;
        nextSqN = '0;
        stimRng = 32'd34237;
        memRng = xorshift(xorshift(32'd34237) ^ 32'h5a5a5a5a);
        for (int k = 0; k < sqnSpan; k++) sbValid[k] = 1'b0;
        // Pages 0, 3 and 6 are 4 MiB superpages
        for (int i = 0; i < 8; i++) begin
            stimRng = xorshift(stimRng);
            pgSuper[i] = (i % 3 == 0);
            pageSeen[i] = 1'b0;
            pgVpn[i] = {10'h040 + 10'(i * 3), pgSuper[i] ? 10'h000 : stimRng[9:0]};
            pgPpn[i] = 20'h80000 | {2'b00, stimRng[27:10]};
            if (pgSuper[i]) pgPpn[i][9:0] = 10'h000;
            pgTbl[i] = 20'h00200 + 20'(i);
            if (pgSuper[i]) begin
                ptMem[{rootPpn, 12'h0} + {20'h0, pgVpn[i][19:10], 2'b00}] =
                    {2'b00, pgPpn[i], 10'h00F};
            end else begin
                ptMem[{rootPpn, 12'h0} + {20'h0, pgVpn[i][19:10], 2'b00}] =
                    {2'b00, pgTbl[i], 10'h001};
                ptMem[{pgTbl[i], 12'h0} + {20'h0, pgVpn[i][9:0], 2'b00}] =
                    {2'b00, pgPpn[i], 10'h00F};
            end
        end
        @(negedge rst);
        while (issued < numOps) begin
            @(posedge clk);
            if (aguValid && !aguStall) issued++;
            branchTaken <= 1'b0;
            stimRng = xorshift(stimRng);
            if (stimRng[8:4] == 5'd0 && nextSqN != '0) begin
                branchTaken <= 1'b1;
                branchSqN <= nextSqN - 1'b1 - `SQN_W'(stimRng[10:9]);
            end
            if (issued >= numOps) begin
                aguValid <= 1'b0;
            end else if (!aguValid || !aguStall) begin
                if (stimRng[1:0] != 2'd0) begin
                    pg = int'(stimRng[14:12]);
                    aguValid <= 1'b1;
                    aguSqN <= nextSqN;
                    aguOp <= stimRng[2] ? mmuPkg::OpStore : mmuPkg::OpLoad;
                    aguAddr <= pgSuper[pg] ? {pgVpn[pg][19:10], stimRng[31:10]}
                                           : {pgVpn[pg], stimRng[27:16]};
                    vmemEn <= (issued >= 100);
                    nextSqN = nextSqN + 1'b1;
                end else begin
                    aguValid <= 1'b0;
                end
            end
        end
        // A branch issued in the last cycle still lasts a single cycle
        @(posedge clk);
        branchTaken <= 1'b0;
        // Drain until every unflushed micro-op is out
        while (pending != 0) @(negedge clk);
        repeat (20) @(negedge clk);
        if (!failed && pending == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
mmuPkg.sv
dataTlb.sv
tlbMissQueue.sv
pageWalker.sv
dataTranslate.sv
tbClock.sv
dataTranslate_assert.sv
tbDataTranslate.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbDataTranslate
FILELIST  = files.f
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
